// File: common/mem_cfg_pkg.sv
/* Geometry of the 2-way cache and the backing memory. Line size and latency are fixed;
   the controller burst timing follows from line_words and mem_lat. */
package mem_cfg_pkg;

   // Word and byte address widths
   localparam int word_w = 16;
   localparam int addr_w = 16;

   // Address split {tag, index, word select, byte bit}
   localparam int tag_w      = 5;
   localparam int index_w    = 8;
   localparam int word_sel_w = 2;
   localparam int word_lsb   = 1;
   localparam int index_lsb  = word_lsb + word_sel_w;
   localparam int tag_lsb    = index_lsb + index_w;

   // Line and set geometry
   localparam int line_words = 4;
   localparam int sets       = 1 << index_w;

   // Main memory of 32K words with a fixed read latency
   localparam int mem_aw  = addr_w - 1;
   localparam int mem_lat = 2;

   // Fill burst ends once the last in-flight read has returned
   localparam int fill_last = line_words + mem_lat - 1;
   localparam int cnt_w     = $clog2(fill_last + 1);

   typedef logic [word_w-1:0] word_t;
   typedef logic [addr_w-1:0] addr_t;

endpackage

// File: common/ctrl_pkg.sv
/* Controller types shared by the FSM, the ways and main memory.
   Field order inside each struct is MSB first. */
package ctrl_pkg;
   import mem_cfg_pkg::*;

   // Controller states
   typedef enum logic [2:0] {
      idle       = 3'd0,
      lookup     = 3'd1,
      write_back = 3'd2,
      fill       = 3'd3,
      finish     = 3'd4
   } ctrl_state_e;

   // CPU operation held for the length of a request
   typedef enum logic {
      op_rd = 1'b0,
      op_wr = 1'b1
   } cpu_op_e;

   // Command to one cache way
   typedef struct packed {
      logic  en;        // way selected
      logic  comp;      // tag compare access
      logic  write;     // write access
      logic  valid_in;  // valid bit for a non-compare write
      addr_t addr;      // byte address of the word
      word_t wdata;     // word to store
   } cache_cmd_t;

   // Response of one way in the same cycle as its command
   typedef struct packed {
      logic             hit;
      logic             valid;
      logic             dirty;
      logic [tag_w-1:0] tag;    // stored tag of the indexed set
      word_t            rword;  // selected word of the line
   } way_status_t;

   // One main memory access
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;   // byte address with bit 0 ignored
      word_t wdata;
   } mem_req_t;

endpackage

// File: cache/cache_way.sv
/* One way of the cache. Reads are combinational from the arrays, writes land at the edge.
   Only valid and dirty bits are reset; tag and data contents are undefined until filled. */
`timescale 1ns/10ps

module cache_way
   import mem_cfg_pkg::*;
   import ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  cache_cmd_t  cmd,
   output way_status_t status
);

   // Per-set state
   logic [sets-1:0]  valid_q;
   logic [sets-1:0]  dirty_q;
   logic [tag_w-1:0] tag_mem [sets];
   word_t            data_mem [sets*line_words];

   // Address fields of the command
   logic [tag_w-1:0]      tag_in;
   logic [index_w-1:0]    idx;
   logic [word_sel_w-1:0] wsel;
   logic                  tag_match;
   logic                  hit;
   logic                  wr_en;

   assign tag_in = cmd.addr[tag_lsb +: tag_w];
   assign idx    = cmd.addr[index_lsb +: index_w];
   assign wsel   = cmd.addr[word_lsb +: word_sel_w];

   // Compare access hits on a valid set with the same tag
   assign tag_match = (tag_mem[idx] == tag_in);
   assign hit       = cmd.en & cmd.comp & valid_q[idx] & tag_match;

   // A compare write only lands on a hit
   assign wr_en = cmd.en & cmd.write & (~cmd.comp | hit);

   always_comb begin
      status.hit   = hit;
      status.valid = valid_q[idx];
      status.dirty = dirty_q[idx];
      status.tag   = tag_mem[idx];
      status.rword = data_mem[{idx, wsel}];
   end

   //////////////////////////////
   // Valid and dirty bits
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (cmd.comp) begin
            // CPU write into a resident line
            dirty_q[idx] <= 1'b1;
         end else begin
            // Line fill from memory
            valid_q[idx] <= cmd.valid_in;
            dirty_q[idx] <= 1'b0;
         end
      end
   end

   // Tag and word arrays
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[{idx, wsel}] <= cmd.wdata;
      end
      if (wr_en && !cmd.comp) begin
         tag_mem[idx] <= tag_in;
      end
   end

endmodule

// File: cache/cache_ctrl.sv
/* Request FSM for the 2-way write-back cache. One request at a time, stall high outside idle.
   Miss timing is fixed by mem_lat; a set byte bit ends the request with err. */
`timescale 1ns/10ps

module cache_ctrl
   import mem_cfg_pkg::*;
   import ctrl_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  addr_t            addr,
   input  word_t            data_in,
   input  logic             rd,
   input  logic             wr,
   input  way_status_t      st0,
   input  way_status_t      st1,
   input  logic [cnt_w-1:0] count,
   input  logic             wb_last,
   input  logic             fill_last,
   input  word_t            mem_rdata,
   output cache_cmd_t       cmd0,
   output cache_cmd_t       cmd1,
   output logic             cnt_clr,
   output logic             cnt_inc,
   output mem_req_t         mem_req,
   output word_t            data_out,
   output logic             done,
   output logic             stall,
   output logic             cache_hit,
   output logic             err
);

   ctrl_state_e state_q, state_d;

   // Captured request
   addr_t   addr_q;
   word_t   data_q;
   cpu_op_e op_q;

   // Replacement state
   logic victim_q;
   logic fill_way_q;
   logic pick_way;

   logic                  misaligned;
   logic [index_w-1:0]    idx;
   logic [word_sel_w-1:0] fill_sel;
   way_status_t           st_pick;
   way_status_t           st_sel;
   cache_cmd_t            cmd;
   logic                  en0, en1;

   assign misaligned = addr_q[0];
   assign idx        = addr_q[index_lsb +: index_w];

   // Word written into the way mem_lat counts behind its read
   assign fill_sel = word_sel_w'(count - cnt_w'(mem_lat));

   // Fill way is the first invalid way, else the toggled victim
   always_comb begin
      if (!st0.valid) begin
         pick_way = 1'b0;
      end else if (!st1.valid) begin
         pick_way = 1'b1;
      end else begin
         pick_way = ~victim_q;
      end
   end

   assign st_pick = pick_way ? st1 : st0;
   assign st_sel  = fill_way_q ? st1 : st0;

   // Hit word in lookup, fill way word in finish
   assign data_out = st1.hit ? st1.rword : st0.rword;
   assign stall    = (state_q != idle);

   // Both ways see the same command, only the enable differs
   always_comb begin
      cmd0    = cmd;
      cmd0.en = en0;
      cmd1    = cmd;
      cmd1.en = en1;
   end

   //////////////////////////////
   // Next state and outputs
   //////////////////////////////
   always_comb begin
      state_d   = state_q;
      cmd       = '0;
      en0       = 1'b0;
      en1       = 1'b0;
      mem_req   = '0;
      cnt_clr   = 1'b0;
      cnt_inc   = 1'b0;
      done      = 1'b0;
      cache_hit = 1'b0;
      err       = 1'b0;

      case (state_q)
         idle: begin
            cnt_clr = 1'b1;
            if (rd || wr) begin
               state_d = lookup;
            end
         end

         lookup: begin
            cnt_clr    = 1'b1;
            // Compare read or compare write in both ways
            cmd.comp   = 1'b1;
            cmd.write  = (op_q == op_wr);
            cmd.addr   = addr_q;
            cmd.wdata  = data_q;
            en0        = ~misaligned;
            en1        = ~misaligned;
            if (misaligned) begin
               done    = 1'b1;
               err     = 1'b1;
               state_d = idle;
            end else if (st0.hit || st1.hit) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               state_d   = idle;
            end else if (st_pick.valid && st_pick.dirty) begin
               state_d = write_back;
            end else begin
               state_d = fill;
            end
         end

         write_back: begin
            // Read the old line word by word, store it at its old tag
            cmd.addr      = {addr_q[addr_w-1:index_lsb], count[word_sel_w-1:0], 1'b0};
            en0           = ~fill_way_q;
            en1           = fill_way_q;
            mem_req.wr    = 1'b1;
            mem_req.addr  = {st_sel.tag, idx, count[word_sel_w-1:0], 1'b0};
            mem_req.wdata = st_sel.rword;
            cnt_inc       = ~wb_last;
            cnt_clr       = wb_last;
            if (wb_last) begin
               state_d = fill;
            end
         end

         fill: begin
            // Reads go out at the first line_words counts
            mem_req.rd   = (count < cnt_w'(line_words));
            mem_req.addr = {addr_q[addr_w-1:index_lsb], count[word_sel_w-1:0], 1'b0};
            // Returning words are stored from count mem_lat on
            cmd.write    = (count >= cnt_w'(mem_lat));
            cmd.valid_in = 1'b1;
            cmd.addr     = {addr_q[addr_w-1:index_lsb], fill_sel, 1'b0};
            cmd.wdata    = mem_rdata;
            en0          = ~fill_way_q;
            en1          = fill_way_q;
            cnt_inc      = ~fill_last;
            cnt_clr      = fill_last;
            if (fill_last) begin
               state_d = finish;
            end
         end

         finish: begin
            // Line is resident now, so the compare access hits
            cmd.comp  = 1'b1;
            cmd.write = (op_q == op_wr);
            cmd.addr  = addr_q;
            cmd.wdata = data_q;
            en0       = ~fill_way_q;
            en1       = fill_way_q;
            done      = 1'b1;
            state_d   = idle;
         end

         default: begin
            state_d = idle;
         end
      endcase
   end

   // State and replacement bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= idle;
         victim_q   <= 1'b0;
         fill_way_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == lookup && !misaligned) begin
            victim_q   <= ~victim_q;
            fill_way_q <= pick_way;
         end
      end
   end

   // Request capture where rd wins over wr
   always_ff @(posedge clk) begin
      if (state_q == idle && (rd || wr)) begin
         addr_q <= addr;
         data_q <= data_in;
         op_q   <= rd ? op_rd : op_wr;
      end
   end

endmodule

// File: hdl/burst_counter.sv
/* Burst word counter. Free running while inc is high; the controller clears it
   at the end of every burst, clr has priority over inc. */
`timescale 1ns/10ps

module burst_counter
   import mem_cfg_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             clr,
   input  logic             inc,
   output logic [cnt_w-1:0] count,
   output logic             wb_last,
   output logic             fill_last
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (clr) begin
         count <= '0;
      end else if (inc) begin
         count <= count + 1'b1;
      end
   end

   // Last word of a write-back
   assign wb_last   = (count == cnt_w'(line_words - 1));
   // Last returning word of a fill
   assign fill_last = (count == cnt_w'(mem_cfg_pkg::fill_last));

endmodule

// File: hdl/main_mem.sv
/* Word-addressed main memory, 32K words, zero at start of simulation.
   Read data appears mem_lat cycles after rd, no back-pressure, one request per cycle. */
`timescale 1ns/10ps

module main_mem
   import mem_cfg_pkg::*;
   import ctrl_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t req,
   output word_t    rdata
);

   word_t mem [1 << mem_aw];

   // Read pipeline whose stage 0 samples the array
   logic [mem_lat-1:0] pipe_vld;
   word_t              pipe_word [mem_lat];
   logic [mem_aw-1:0]  waddr;

   assign waddr = req.addr[addr_w-1:1];

   initial begin
      for (int i = 0; i < (1 << mem_aw); i++) begin
         mem[i] = '0;
      end
   end

   // Writes land at the edge
   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem[waddr] <= req.wdata;
      end
   end

   //////////////////////////////
   // Fixed latency read path
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pipe_vld <= '0;
         for (int i = 0; i < mem_lat; i++) begin
            pipe_word[i] <= '0;
         end
      end else begin
         pipe_vld[0]  <= req.rd;
         pipe_word[0] <= mem[waddr];
         for (int i = 1; i < mem_lat; i++) begin
            pipe_vld[i]  <= pipe_vld[i-1];
            pipe_word[i] <= pipe_word[i-1];
         end
      end
   end

   // Zero when no read is returning
   assign rdata = pipe_vld[mem_lat-1] ? pipe_word[mem_lat-1] : '0;

endmodule

// File: hdl/mem_system.sv
/* Top level memory system: FSM, burst counter, two cache ways and main memory.
   CPU requests are levels sampled only while stall is low. */
`timescale 1ns/10ps

module mem_system
   import mem_cfg_pkg::*;
   import ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  addr_t addr,
   input  word_t data_in,
   input  logic  rd,
   input  logic  wr,
   output word_t data_out,
   output logic  done,
   output logic  stall,
   output logic  cache_hit,
   output logic  err
);

   // Way commands and responses
   cache_cmd_t  cmd0, cmd1;
   way_status_t st0, st1;

   // Memory side
   mem_req_t mem_req;
   word_t    mem_rdata;

   // Burst counter
   logic [cnt_w-1:0] count;
   logic             cnt_clr;
   logic             cnt_inc;
   logic             cnt_wb_last;
   logic             cnt_fill_last;

   cache_ctrl u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .st0       (st0),
      .st1       (st1),
      .count     (count),
      .wb_last   (cnt_wb_last),
      .fill_last (cnt_fill_last),
      .mem_rdata (mem_rdata),
      .cmd0      (cmd0),
      .cmd1      (cmd1),
      .cnt_clr   (cnt_clr),
      .cnt_inc   (cnt_inc),
      .mem_req   (mem_req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   burst_counter u_cnt (
      .clk       (clk),
      .arst_n    (arst_n),
      .clr       (cnt_clr),
      .inc       (cnt_inc),
      .count     (count),
      .wb_last   (cnt_wb_last),
      .fill_last (cnt_fill_last)
   );

   cache_way u_way0 (
      .clk    (clk),
      .arst_n (arst_n),
      .cmd    (cmd0),
      .status (st0)
   );

   cache_way u_way1 (
      .clk    (clk),
      .arst_n (arst_n),
      .cmd    (cmd1),
      .status (st1)
   );

   main_mem u_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .rdata  (mem_rdata)
   );

endmodule

// File: verif/mem_system_props.sv
/* FSM timing properties, bound into cache_ctrl. The longest request, a dirty miss,
   must finish within 12 edges of acceptance. */
`timescale 1ns/10ps

module mem_system_props
   import ctrl_pkg::*;
(
   input logic        clk,
   input logic        arst_n,
   input ctrl_state_e state_q,
   input logic        done,
   input logic        stall,
   input logic        err
);

   // Count of failed properties
   int fail_count = 0;

   // Edges spent outside idle for the current request
   int busy_cnt;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_cnt <= 0;
      end else if (state_q == idle) begin
         busy_cnt <= 0;
      end else begin
         busy_cnt <= busy_cnt + 1;
      end
   end

   //////////////////////////////
   // Controller properties
   //////////////////////////////
   a_no_done_in_idle: assert property (@(posedge clk) disable iff (!arst_n)
      (state_q == idle) |-> !done)
      else begin
         fail_count++;
         $error("done high while the controller is idle");
      end

   a_stall_outside_idle: assert property (@(posedge clk) disable iff (!arst_n)
      stall == (state_q != idle))
      else begin
         fail_count++;
         $error("stall does not match the idle state");
      end

   // Dirty miss is the worst case at 12 edges
   a_done_in_time: assert property (@(posedge clk) disable iff (!arst_n)
      (state_q != idle) |-> (busy_cnt < 12))
      else begin
         fail_count++;
         $error("request still busy 12 edges after acceptance");
      end

   a_err_with_done: assert property (@(posedge clk) disable iff (!arst_n)
      err |-> done)
      else begin
         fail_count++;
         $error("err raised without done");
      end

endmodule

bind cache_ctrl mem_system_props u_props (
   .clk     (clk),
   .arst_n  (arst_n),
   .state_q (state_q),
   .done    (done),
   .stall   (stall),
   .err     (err)
);

// File: verif/mem_system_checker.sv
/* Watches the CPU port and compares each finished request with the expectation
   the testbench holds on exp_* for the whole request. One request in flight at a time. */
`timescale 1ns/10ps

module mem_system_checker
   import mem_cfg_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         rd,
   input  logic         wr,
   input  logic         stall,
   input  logic         done,
   input  logic         cache_hit,
   input  logic         err,
   input  word_t        data_out,
   input  logic [127:0] exp_name,
   input  logic         exp_rd,
   input  word_t        exp_data,
   input  logic         exp_hit,
   input  logic         exp_err,
   input  int           exp_lat,
   output int           pass_cnt,
   output int           fail_cnt
);

   // Dirty miss is the slowest path
   localparam int max_lat = 12;

   logic busy;
   logic stall_ok;
   int   edges;
   logic ok;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy     = 1'b0;
         stall_ok = 1'b1;
         edges    = 0;
         pass_cnt = 0;
         fail_cnt = 0;
      end else if (!busy) begin
         if (done) begin
            fail_cnt = fail_cnt + 1;
            $display("done seen with no request outstanding");
         end
         // Acceptance edge
         if (!stall && (rd || wr)) begin
            busy     = 1'b1;
            stall_ok = 1'b1;
            edges    = 0;
         end
      end else begin
         edges = edges + 1;
         // stall has to stay high up to and including the done edge
         if (!stall) begin
            stall_ok = 1'b0;
         end
         if (done) begin
            ok = 1'b1;
            if (!stall_ok) begin
               $display("%0s: stall dropped while the request was in progress", exp_name);
               ok = 1'b0;
            end
            if (err !== exp_err) begin
               $display("** Error %0s: err expected %0b, actual %0b", exp_name, exp_err, err);
               ok = 1'b0;
            end
            if (cache_hit !== exp_hit) begin
               $display("** Error %0s: cache_hit expected %0b, actual %0b",
                        exp_name, exp_hit, cache_hit);
               ok = 1'b0;
            end
            // data_out only means something on a good read
            if (exp_rd && !exp_err && data_out !== exp_data) begin
               $display("** Error %0s: data_out expected %h, actual %h",
                        exp_name, exp_data, data_out);
               ok = 1'b0;
            end
            if (edges != exp_lat) begin
               $display("** Error %0s: done edge expected %0d, actual %0d",
                        exp_name, exp_lat, edges);
               ok = 1'b0;
            end
            if (ok) begin
               pass_cnt = pass_cnt + 1;
               $display("%0s: ok, done at edge %0d", exp_name, edges);
            end else begin
               fail_cnt = fail_cnt + 1;
               $display("%0s: mismatch", exp_name);
            end
            busy = 1'b0;
         end else if (edges >= max_lat) begin
            fail_cnt = fail_cnt + 1;
            $display("%0s: no done within %0d cycles of the request", exp_name, max_lat);
            busy = 1'b0;
         end
      end
   end

endmodule

// File: verif/mem_system_tb.sv
/* Testbench for the memory system. Expected results come from a behavioral model of both
   ways, the victim bit and main memory; requests go one at a time. */
`timescale 1ns/10ps

module mem_system_tb
   import mem_cfg_pkg::*;
();

   localparam int n_req      = 317;
   localparam int max_cycles = n_req * 13 + 5 + 200;

   logic  clk;
   logic  arst_n;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // Expectation for the request in flight
   logic [127:0] exp_name;
   logic         exp_rd;
   word_t        exp_data;
   logic         exp_hit;
   logic         exp_err;
   int           exp_lat;
   int           pass_cnt;
   int           fail_cnt;
   int           cycle_cnt;

   //////////////////////////////
   // Reference model state
   //////////////////////////////
   word_t            mem_model [1 << mem_aw];
   logic [tag_w-1:0] tag_m [2][sets];
   logic             val_m [2][sets];
   logic             dirty_m [2][sets];
   word_t            data_m [2][sets][line_words];
   logic             victim_m;

   mem_system u_mem_system (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   mem_system_checker u_checker (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd        (rd),
      .wr        (wr),
      .stall     (stall),
      .done      (done),
      .cache_hit (cache_hit),
      .err       (err),
      .data_out  (data_out),
      .exp_name  (exp_name),
      .exp_rd    (exp_rd),
      .exp_data  (exp_data),
      .exp_hit   (exp_hit),
      .exp_err   (exp_err),
      .exp_lat   (exp_lat),
      .pass_cnt  (pass_cnt),
      .fail_cnt  (fail_cnt)
   );

   always #50 clk = ~clk;

   // Run limit of 13 cycles per request plus reset and margin
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Run stopped: requests still pending after %0d cycles", max_cycles);
         $display("Test failed");
         $finish;
      end
   end

   function automatic addr_t make_addr(input int tg, input int ix, input int ws);
      return {tag_w'(tg), index_w'(ix), word_sel_w'(ws), 1'b0};
   endfunction

   // Expected outcome of one request; updates the model like the cache would
   function automatic void ref_access(input logic is_wr, input addr_t a, input word_t wdata,
                                      output word_t e_data, output logic e_hit,
                                      output logic e_err, output int e_lat);
      logic [tag_w-1:0]      tg;
      logic [index_w-1:0]    ix;
      logic [word_sel_w-1:0] ws;
      int                    way;
      int                    i;
      tg     = a[tag_lsb +: tag_w];
      ix     = a[index_lsb +: index_w];
      ws     = a[word_lsb +: word_sel_w];
      e_data = '0;
      e_hit  = 1'b0;
      e_err  = 1'b0;
      e_lat  = 1;
      way    = -1;
      // Misaligned request changes nothing, not even the victim bit
      if (a[0]) begin
         e_err = 1'b1;
         return;
      end
      victim_m = ~victim_m;
      for (i = 0; i < 2; i++) begin
         if (val_m[i][ix] && tag_m[i][ix] == tg) begin
            way = i;
         end
      end
      if (way >= 0) begin
         e_hit = 1'b1;
      end else begin
         // First invalid way, else the toggled victim
         if (!val_m[0][ix]) begin
            way = 0;
         end else if (!val_m[1][ix]) begin
            way = 1;
         end else begin
            way = int'(victim_m);
         end
         e_lat = 8;
         if (val_m[way][ix] && dirty_m[way][ix]) begin
            e_lat = 12;
            for (i = 0; i < line_words; i++) begin
               mem_model[{tag_m[way][ix], ix, 2'(i)}] = data_m[way][ix][i];
            end
         end
         for (i = 0; i < line_words; i++) begin
            data_m[way][ix][i] = mem_model[{tg, ix, 2'(i)}];
         end
         tag_m[way][ix]   = tg;
         val_m[way][ix]   = 1'b1;
         dirty_m[way][ix] = 1'b0;
      end
      if (is_wr) begin
         data_m[way][ix][ws] = wdata;
         dirty_m[way][ix]    = 1'b1;
      end else begin
         e_data = data_m[way][ix][ws];
      end
   endfunction

   // One request waits for idle, pulses rd or wr and waits for done
   task automatic do_request(input logic [127:0] name, input logic is_wr, input addr_t a,
                             input word_t d);
      word_t e_data;
      logic  e_hit;
      logic  e_err;
      int    e_lat;
      while (stall) begin
         @(posedge clk);
         #5;
      end
      ref_access(is_wr, a, d, e_data, e_hit, e_err, e_lat);
      exp_name = name;
      exp_rd   = !is_wr;
      exp_data = e_data;
      exp_hit  = e_hit;
      exp_err  = e_err;
      exp_lat  = e_lat;
      addr     = a;
      data_in  = d;
      rd       = !is_wr;
      wr       = is_wr;
      @(posedge clk);
      #5;
      rd = 1'b0;
      wr = 1'b0;
      while (!done) begin
         @(posedge clk);
         #5;
      end
      @(posedge clk);
      #5;
   endtask

   initial begin
      int i;
      int prop_fails;
      void'($urandom(32'h6f61));
      clk       = 1'b0;
      arst_n    = 1'b0;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      exp_name  = '0;
      exp_rd    = 1'b0;
      exp_data  = '0;
      exp_hit   = 1'b0;
      exp_err   = 1'b0;
      exp_lat   = 0;
      cycle_cnt = 0;
      victim_m  = 1'b0;
      for (i = 0; i < (1 << mem_aw); i++) begin
         mem_model[i] = '0;
      end
      for (i = 0; i < sets; i++) begin
         val_m[0][i]   = 1'b0;
         val_m[1][i]   = 1'b0;
         dirty_m[0][i] = 1'b0;
         dirty_m[1][i] = 1'b0;
      end
      repeat (5) @(posedge clk);
      #5;
      arst_n = 1'b1;

      // Cold read, then the same word again
      do_request("t1_cold_read", 1'b0, make_addr(1, 16, 2), '0);
      do_request("t1_reread", 1'b0, make_addr(1, 16, 2), '0);
      // Write miss, then read back
      do_request("t2_write_miss", 1'b1, make_addr(2, 17, 3), 16'hbeef);
      do_request("t2_read_back", 1'b0, make_addr(2, 17, 3), '0);
      // Three tags on one set, the third evicts a dirty line
      do_request("t3_fill_way0", 1'b1, make_addr(1, 18, 0), 16'h1111);
      do_request("t3_fill_way1", 1'b1, make_addr(2, 18, 0), 16'h2222);
      do_request("t3_evict", 1'b0, make_addr(3, 18, 0), '0);
      do_request("t3_read_tag1", 1'b0, make_addr(1, 18, 0), '0);
      do_request("t3_read_tag2", 1'b0, make_addr(2, 18, 0), '0);
      // Random mix over 4 tags and 4 sets
      for (i = 0; i < 300; i++) begin
         do_request("t4_random", 1'($urandom_range(1)),
                    make_addr($urandom_range(3), $urandom_range(3), $urandom_range(3)),
                    16'($urandom));
      end
      // Misaligned accesses leave the t1 line alone
      do_request("t5_misaligned_rd", 1'b0, make_addr(1, 16, 2) | 16'h1, '0);
      do_request("t5_misaligned_wr", 1'b1, make_addr(1, 16, 2) | 16'h1, 16'h5a5a);
      do_request("t5_state_kept", 1'b0, make_addr(1, 16, 2), '0);
      // Path timing of a clean miss, a hit and a dirty miss
      do_request("t6_clean_miss", 1'b0, make_addr(1, 32, 1), '0);
      do_request("t6_hit", 1'b0, make_addr(1, 32, 1), '0);
      do_request("t6_dirty_way0", 1'b1, make_addr(1, 33, 0), 16'h0a0a);
      do_request("t6_dirty_way1", 1'b1, make_addr(2, 33, 0), 16'h0b0b);
      do_request("t6_dirty_miss", 1'b0, make_addr(3, 33, 0), '0);

      prop_fails = u_mem_system.u_ctrl.u_props.fail_count;
      $display("Checks: %0d passed, %0d failed, %0d assertion failures",
               pass_cnt, fail_cnt, prop_fails);
      if (fail_cnt == 0 && pass_cnt == n_req && prop_fails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
common/mem_cfg_pkg.sv
common/ctrl_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
hdl/burst_counter.sv
hdl/main_mem.sv
hdl/mem_system.sv
verif/mem_system_props.sv
verif/mem_system_checker.sv
verif/mem_system_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_system_tb
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
